// File: hdl/vga_pkg.sv
// VGA overlay package: pixel stream bundle, width types, board cell states and palette.
package vga_pkg;

    // Widths that carry a meaning.
    typedef logic [10:0] hcount_t;       // Horizontal pixel counter.
    typedef logic [10:0] vcount_t;       // Vertical line counter.
    typedef logic [11:0] rgb_t;          // 4 bits per channel, R in the top nibble.
    typedef logic [7:0]  grid_addr_t;    // {column, row}, one nibble each.
    typedef logic [1:0]  cell_status_t;

    // Board cell states.
    localparam cell_status_t CELL_EMPTY = 2'd0;
    localparam cell_status_t CELL_SHIP  = 2'd1;
    localparam cell_status_t CELL_HIT   = 2'd2;
    localparam cell_status_t CELL_MISS  = 2'd3;

    // One pixel of the stream, 38 bits in total.
    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    hsync;
        logic    vsync;
        logic    hblnk;
        logic    vblnk;
        rgb_t    rgb;
    } vga_bus_t;

    // Palette.
    localparam rgb_t RGB_BLACK  = 12'h000;
    localparam rgb_t RGB_WATER  = 12'h00A;   // Empty cell interior.
    localparam rgb_t RGB_SHIP   = 12'h0F0;
    localparam rgb_t RGB_HIT    = 12'hF00;
    localparam rgb_t RGB_MISS   = 12'hFFF;
    localparam rgb_t RGB_BORDER = 12'h888;

    // Board geometry in cells and pixels.
    localparam int GRID_COLS    = 12;
    localparam int GRID_ROWS    = 12;
    localparam int CELL_SIZE    = 32;
    localparam int BORDER_WIDTH = 2;

    // Maps a cell state to its interior colour.
    function automatic rgb_t status_rgb(input cell_status_t status);
        case (status)
            CELL_SHIP: return RGB_SHIP;
            CELL_HIT:  return RGB_HIT;
            CELL_MISS: return RGB_MISS;
            default:   return RGB_WATER;
        endcase
    endfunction

endpackage

// File: hdl/vga_timing.sv
// VGA timing generator: pixel and line counters with sync and blanking.
module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_TOTAL  = 1056,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_TOTAL  = 628
) (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_bus_t bus
);

    import vga_pkg::*;

    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;   // First pixel after the pulse.
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    hcount_t hcount;
    vcount_t vcount;
    logic    line_end;
    logic    frame_end;

    assign line_end  = (hcount == hcount_t'(H_TOTAL - 1));
    assign frame_end = (vcount == vcount_t'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Line counter steps once per wrap of the pixel counter.
    always_ff @(posedge clk) begin
        if (rst) begin
            vcount <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    always_comb begin
        bus.hcount = hcount;
        bus.vcount = vcount;
        bus.hblnk  = (hcount >= hcount_t'(H_ACTIVE));
        bus.vblnk  = (vcount >= vcount_t'(V_ACTIVE));
        bus.hsync  = (hcount >= hcount_t'(H_SYNC_START)) &&
                     (hcount <  hcount_t'(H_SYNC_END));   // Positive polarity.
        bus.vsync  = (vcount >= vcount_t'(V_SYNC_START)) &&
                     (vcount <  vcount_t'(V_SYNC_END));
        bus.rgb    = RGB_BLACK;                          // Background is black.
    end

endmodule

// File: hdl/pixel_delay.sv
// Pixel stream delay line of DEPTH struct registers.
module pixel_delay #(
    parameter int DEPTH = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_bus_t din,
    output vga_pkg::vga_bus_t dout
);

    import vga_pkg::*;

    vga_bus_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            // Shift towards the output.
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];   // Oldest pixel.

endmodule

// File: hdl/board_memory.sv
// Board store: 256 cell states with host write port, clear sweep and registered read.
module board_memory (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  vga_pkg::grid_addr_t   wr_addr,
    input  vga_pkg::cell_status_t wr_status,
    input  vga_pkg::grid_addr_t   rd_addr,
    output vga_pkg::cell_status_t rd_status,
    output logic                  clear_busy
);

    import vga_pkg::*;

    localparam int ENTRIES = 2 ** $bits(grid_addr_t);

    cell_status_t mem [ENTRIES];
    grid_addr_t   clear_addr;
    logic         clear_armed;   // Sweep starts on the first cycle out of reset.
    logic         host_wr;

    assign host_wr = wr_en && !clear_busy && !clear_armed;

    always_ff @(posedge clk) begin
        if (rst) begin
            clear_armed <= 1'b1;
            clear_busy  <= 1'b0;
            clear_addr  <= '0;
        end else if (clear_armed) begin
            clear_armed <= 1'b0;
            clear_busy  <= 1'b1;
        end else if (clear_busy) begin
            clear_addr <= clear_addr + 1'b1;
            if (&clear_addr) clear_busy <= 1'b0;   // Last entry written.
        end
    end

    // Sweep has priority; host writes are dropped while it runs.
    always_ff @(posedge clk) begin
        if (clear_busy) begin
            mem[clear_addr] <= CELL_EMPTY;
        end else if (host_wr) begin
            mem[wr_addr] <= wr_status;
        end
    end

    // Read before write on the same address.
    always_ff @(posedge clk) begin
        if (rst) rd_status <= CELL_EMPTY;
        else     rd_status <= mem[rd_addr];
    end

endmodule

// File: hdl/draw_ships.sv
// Board overlay: addresses the board per pixel and paints cells and borders on the stream.
module draw_ships #(
    parameter int X_POS = 0,
    parameter int Y_POS = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::cell_status_t grid_status,
    input  vga_pkg::vga_bus_t     vga_in,
    output vga_pkg::grid_addr_t   grid_addr,
    output vga_pkg::vga_bus_t     vga_out
);

    import vga_pkg::*;

    localparam int GRID_W = GRID_COLS * CELL_SIZE;   // 384 pixels.
    localparam int GRID_H = GRID_ROWS * CELL_SIZE;

    hcount_t    h_rel;
    vcount_t    v_rel;
    grid_addr_t grid_addr_nxt;
    vga_bus_t   vga_dly;
    hcount_t    dly_h_rel;
    vcount_t    dly_v_rel;
    logic       in_grid;
    logic       on_border;
    vga_bus_t   vga_nxt;

    // Position relative to the grid origin.
    assign h_rel = vga_in.hcount - hcount_t'(X_POS);
    assign v_rel = vga_in.vcount - vcount_t'(Y_POS);

    // Column in the upper nibble, row in the lower one.
    assign grid_addr_nxt = {h_rel[8:5], v_rel[8:5]};

    // Two stages match the address register plus the board read.
    pixel_delay #(
        .DEPTH(2)
    ) u_pixel_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (vga_in),
        .dout (vga_dly)
    );

    assign dly_h_rel = vga_dly.hcount - hcount_t'(X_POS);
    assign dly_v_rel = vga_dly.vcount - vcount_t'(Y_POS);

    always_comb begin
        in_grid = (vga_dly.hcount >= hcount_t'(X_POS)) &&
                  (vga_dly.hcount <  hcount_t'(X_POS + GRID_W)) &&
                  (vga_dly.vcount >= vcount_t'(Y_POS)) &&
                  (vga_dly.vcount <  vcount_t'(Y_POS + GRID_H)) &&
                  !vga_dly.hblnk && !vga_dly.vblnk;
        // Top and left edge of every cell.
        on_border = (dly_h_rel[4:0] < 5'(BORDER_WIDTH)) ||
                    (dly_v_rel[4:0] < 5'(BORDER_WIDTH));
    end

    always_comb begin
        vga_nxt = vga_dly;
        if (in_grid) begin
            if (on_border) vga_nxt.rgb = RGB_BORDER;
            else           vga_nxt.rgb = status_rgb(grid_status);   // Status lines up here.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grid_addr <= '0;
            vga_out   <= '0;
        end else begin
            grid_addr <= grid_addr_nxt;
            vga_out   <= vga_nxt;
        end
    end

endmodule

// File: hdl/battle_display.sv
// Naval battle display top: VGA timing, board store and grid overlay on one clock.
module battle_display #(
    parameter int X_POS    = 208,
    parameter int Y_POS    = 108,
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_TOTAL  = 1056,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_TOTAL  = 628
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  vga_pkg::grid_addr_t   wr_addr,
    input  vga_pkg::cell_status_t wr_status,
    output vga_pkg::vga_bus_t     vga_out,
    output logic                  clear_busy
);

    import vga_pkg::*;

    vga_bus_t     bus_raw;       // Counters and syncs, black background.
    grid_addr_t   grid_addr;
    cell_status_t grid_status;   // One cycle behind grid_addr.

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) u_vga_timing (
        .clk (clk),
        .rst (rst),
        .bus (bus_raw)
    );

    board_memory u_board_memory (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_status  (wr_status),
        .rd_addr    (grid_addr),
        .rd_status  (grid_status),
        .clear_busy (clear_busy)
    );

    draw_ships #(
        .X_POS (X_POS),
        .Y_POS (Y_POS)
    ) u_draw_ships (
        .clk         (clk),
        .rst         (rst),
        .grid_status (grid_status),
        .vga_in      (bus_raw),
        .grid_addr   (grid_addr),
        .vga_out     (vga_out)
    );

endmodule

// File: dv/battle_display_props.sv
// Overlay stream checks: output pixel order, sync inside blanking and board read range.
module battle_display_props #(
    parameter int X_POS = 0,
    parameter int Y_POS = 0
) (
    input logic                clk,
    input logic                rst,
    input vga_pkg::vga_bus_t   vga_in,
    input vga_pkg::grid_addr_t grid_addr,
    input vga_pkg::vga_bus_t   vga_out
);

    import vga_pkg::*;

    logic in_grid_in;   // Incoming pixel lies on the board.

    assign in_grid_in = (vga_in.hcount >= hcount_t'(X_POS)) &&
                        (vga_in.hcount <  hcount_t'(X_POS + GRID_COLS * CELL_SIZE)) &&
                        (vga_in.vcount >= vcount_t'(Y_POS)) &&
                        (vga_in.vcount <  vcount_t'(Y_POS + GRID_ROWS * CELL_SIZE)) &&
                        !vga_in.hblnk && !vga_in.vblnk;

    hcount_order: assert property (@(posedge clk) disable iff (rst)
        (vga_out.hcount == $past(vga_out.hcount) + hcount_t'(1)) || (vga_out.hcount == '0))
        else $error("Output hcount neither advanced by one nor wrapped to zero");

    hsync_in_blank: assert property (@(posedge clk) disable iff (rst)
        vga_out.hsync |-> vga_out.hblnk)
        else $error("Output hsync outside horizontal blanking");

    // The address register lags its pixel by one cycle.
    read_in_range: assert property (@(posedge clk) disable iff (rst)
        $past(in_grid_in) |-> (grid_addr[7:4] < 4'(GRID_COLS)) && (grid_addr[3:0] < 4'(GRID_ROWS)))
        else $error("Board read outside the 12 by 12 grid");

endmodule

bind draw_ships battle_display_props #(
    .X_POS (X_POS),
    .Y_POS (Y_POS)
) u_props (
    .clk       (clk),
    .rst       (rst),
    .vga_in    (vga_in),
    .grid_addr (grid_addr),
    .vga_out   (vga_out)
);

// File: dv/battle_display_tb.sv
// Battle display testbench: host writes, a frame reference model and a per-pixel comparison.
module battle_display_tb;

    import vga_pkg::*;

    localparam int X_POS    = 208;
    localparam int Y_POS    = 108;
    localparam int H_ACTIVE = 800;
    localparam int H_FRONT  = 40;
    localparam int H_SYNC   = 128;
    localparam int H_TOTAL  = 1056;
    localparam int V_ACTIVE = 600;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 4;
    localparam int V_TOTAL  = 628;

    localparam int FRAME_CYCLES      = H_TOTAL * V_TOTAL;
    localparam int PIPE_LATENCY      = 3;        // Timing counters to vga_out.
    localparam int RESET_CYCLES      = 10;
    localparam int CLEAR_CYCLES      = 256;
    localparam int NUM_RANDOM_WRITES = 40;
    localparam int NUM_REWRITES      = 8;
    localparam int TIMEOUT_CYCLES    = 3 * FRAME_CYCLES + 1000;
    localparam int MIN_SAMPLES       = PIPE_LATENCY + 2 * FRAME_CYCLES + V_ACTIVE * H_TOTAL;

    logic         clk;
    logic         rst;
    logic         wr_en;
    grid_addr_t   wr_addr;
    cell_status_t wr_status;
    vga_bus_t     vga_out;
    logic         clear_busy;

    cell_status_t shadow [GRID_COLS][GRID_ROWS];   // Board as the host sees it.
    int           written [$];                     // Cells hit by the random writes.
    int           seed = 32'heefc_fe45;
    int           out_samples = 0;
    int           reset_edges = 0;
    int           cycle_count = 0;
    int           wait_cycles;
    int           busy_cycles;
    int           idx;
    int           col;
    int           row;
    cell_status_t state;
    logic [3:0]   seen_states;
    vga_bus_t     exp_bus;

    battle_display #(
        .X_POS    (X_POS),
        .Y_POS    (Y_POS),
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_status  (wr_status),
        .vga_out    (vga_out),
        .clear_busy (clear_busy)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    // Colour of one screen position from the grid geometry and the shadow board.
    function automatic rgb_t expected_rgb(input int h, input int v);
        int dx;
        int dy;
        if (h >= H_ACTIVE || v >= V_ACTIVE) return RGB_BLACK;
        if (h < X_POS || h >= X_POS + GRID_COLS * CELL_SIZE) return RGB_BLACK;
        if (v < Y_POS || v >= Y_POS + GRID_ROWS * CELL_SIZE) return RGB_BLACK;
        dx = h - X_POS;
        dy = v - Y_POS;
        if ((dx % CELL_SIZE) < BORDER_WIDTH || (dy % CELL_SIZE) < BORDER_WIDTH) begin
            return RGB_BORDER;
        end
        case (shadow[dx / CELL_SIZE][dy / CELL_SIZE])
            CELL_SHIP: return RGB_SHIP;
            CELL_HIT:  return RGB_HIT;
            CELL_MISS: return RGB_MISS;
            default:   return RGB_WATER;
        endcase
    endfunction

    // Full output pixel for the p-th pixel since the counters left reset.
    function automatic vga_bus_t expected_bus(input int p);
        vga_bus_t bus;
        int       h;
        int       v;
        h = p % H_TOTAL;
        v = (p / H_TOTAL) % V_TOTAL;
        bus.hcount = hcount_t'(h);
        bus.vcount = vcount_t'(v);
        bus.hsync  = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        bus.vsync  = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        bus.hblnk  = (h >= H_ACTIVE);
        bus.vblnk  = (v >= V_ACTIVE);
        bus.rgb    = expected_rgb(h, v);
        return bus;
    endfunction

    function automatic string test_name(input int sample);
        if (sample < PIPE_LATENCY) return "reset_state";
        case ((sample - PIPE_LATENCY) / FRAME_CYCLES)
            0:       return "empty_board";
            1:       return "cell_states";
            default: return "rewrite";
        endcase
    endfunction

    task automatic drive_write(input int c, input int r, input cell_status_t status);
        wr_en     = 1'b1;
        wr_addr   = grid_addr_t'(c * 16 + r);   // Column in the upper nibble.
        wr_status = status;
    endtask

    task automatic write_cell(input int c, input int r, input cell_status_t status);
        @(negedge clk);
        drive_write(c, r, status);
        shadow[c][r] = status;
    endtask

    task automatic end_writes();
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Returns at the start of the next vertical blanking on the output.
    task automatic wait_frame_end();
        do @(negedge clk); while (vga_out.vblnk);
        do @(negedge clk); while (!vga_out.vblnk);
    endtask

    // Compares every output pixel with the reference model.
    always @(posedge clk) begin
        if (rst) begin
            if (reset_edges > 0) begin   // Outputs are unknown before the first reset edge.
                assert (vga_out === '0) else report_failure($sformatf(
                    "Mismatch in reset_state: expected %h, actual %h", 38'h0, vga_out));
                assert (clear_busy === 1'b0) else report_failure($sformatf(
                    "Mismatch in reset_state clear_busy: expected 0, actual %b", clear_busy));
            end
            reset_edges++;
            out_samples = 0;
        end else begin
            if (out_samples < PIPE_LATENCY) exp_bus = '0;
            else exp_bus = expected_bus(out_samples - PIPE_LATENCY);
            assert (vga_out.rgb === exp_bus.rgb) else report_failure($sformatf(
                "Mismatch in %s rgb at (%0d,%0d): expected %h, actual %h",
                test_name(out_samples), exp_bus.hcount, exp_bus.vcount,
                exp_bus.rgb, vga_out.rgb));
            assert (vga_out[37:12] === exp_bus[37:12]) else report_failure($sformatf(
                "Mismatch in %s timing: expected h=%0d v=%0d sync=%b%b blnk=%b%b, %s",
                test_name(out_samples), exp_bus.hcount, exp_bus.vcount, exp_bus.hsync,
                exp_bus.vsync, exp_bus.hblnk, exp_bus.vblnk,
                $sformatf("actual h=%0d v=%0d sync=%b%b blnk=%b%b", vga_out.hcount,
                          vga_out.vcount, vga_out.hsync, vga_out.vsync,
                          vga_out.hblnk, vga_out.vblnk)));
            out_samples++;
        end
    end

    // Watchdog.
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Timeout.");
    end

    initial begin
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_status = CELL_EMPTY;
        for (col = 0; col < GRID_COLS; col++) begin
            for (row = 0; row < GRID_ROWS; row++) shadow[col][row] = CELL_EMPTY;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        wait_cycles = 0;
        while (!clear_busy && wait_cycles < 4) begin
            @(negedge clk);
            wait_cycles++;
        end
        assert (clear_busy === 1'b1) else report_failure("clear_busy did not rise after reset");

        // The sweep has already cleared cell (5,7) when this write arrives.
        busy_cycles = 0;
        while (clear_busy) begin
            if (busy_cycles == CLEAR_CYCLES - 16) drive_write(5, 7, CELL_HIT);
            else wr_en = 1'b0;
            busy_cycles++;
            @(negedge clk);
        end
        wr_en = 1'b0;
        assert (busy_cycles == CLEAR_CYCLES) else report_failure($sformatf(
            "Mismatch in clear_sweep length: expected %0d, actual %0d",
            CLEAR_CYCLES, busy_cycles));

        // Frame 0 shows the empty board. Fill cells in its blanking.
        wait_frame_end();
        for (idx = 0; idx < NUM_RANDOM_WRITES; idx++) begin
            col = int'($unsigned($random(seed)) % GRID_COLS);
            row = int'($unsigned($random(seed)) % GRID_ROWS);
            if (idx >= NUM_RANDOM_WRITES - 4) begin
                state = cell_status_t'(idx - (NUM_RANDOM_WRITES - 4));   // One of each state.
            end else begin
                state = cell_status_t'($unsigned($random(seed)) % 4);
            end
            write_cell(col, row, state);
            written.push_back(col * 16 + row);
        end
        end_writes();

        seen_states = '0;
        for (col = 0; col < GRID_COLS; col++) begin
            for (row = 0; row < GRID_ROWS; row++) seen_states[shadow[col][row]] = 1'b1;
        end
        assert (&seen_states) else report_failure("The random writes left a cell state unused");

        // Frame 1 shows the written board. Step some cells to the next state.
        wait_frame_end();
        for (idx = 0; idx < NUM_REWRITES; idx++) begin
            col = written[idx] / 16;
            row = written[idx] % 16;
            write_cell(col, row, cell_status_t'(shadow[col][row] + 1));
        end
        end_writes();

        wait_frame_end();   // Frame 2 checked against the rewritten board.
        if (out_samples >= MIN_SAMPLES) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Too few output pixels were compared: %0d", out_samples);
            $display("Testbench failed");
            $fatal(1, "Incomplete run.");
        end
    end

endmodule

// File: build.f
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/pixel_delay.sv
hdl/board_memory.sv
hdl/draw_ships.sv
hdl/battle_display.sv
dv/battle_display_props.sv
dv/battle_display_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module battle_display_tb \
    -f build.f \
    -o battle_display_sim

output="$(./obj_dir/battle_display_sim 2>&1 || true)"
echo "$output"

if grep -qx "Testbench passed" <<< "$output"; then
    exit 0
fi
exit 1
